// ==== bench/vfront_model.svh ====
//////////////////////////////////////////////////
// reference model of the front end, included inside the
// testbench module after the package imports
//////////////////////////////////////////////////

`ifndef VFRONT_MODEL_SVH
`define VFRONT_MODEL_SVH

// expected results in commit order, one entry per committed word
bit          exp_xv[$];
logic [31:0] exp_x[$];
logic [31:0] exp_vtype[$];
instr_word_u exp_ops[$];            // operations still to be dispatched

logic [31:0] last_vl    = 32'h0;
logic [31:0] last_vtype = 32'h8000_0000;   // ill after reset

// operations in flight, due is the retire cycle
logic [31:0] fl_rd[$];
logic [31:0] fl_wr[$];
int          fl_due[$];

function automatic logic [31:0] vlmax_for(input logic [1:0] sew, input logic [1:0] lmul);
    int elem_bits;
    elem_bits = 8 * (1 << sew);
    return (`VREG_W / elem_bits) * (1 << lmul);
endfunction

function automatic logic [31:0] expected_vl(input instr_word_u w, input logic [31:0] avl);
    logic [31:0] vmax;
    if (w.cfg.vsew == VSEW_INVALID || avl == 32'h0) begin
        return 32'h0;
    end
    vmax = vlmax_for(w.cfg.vsew, w.cfg.lmul);
    return (avl < vmax) ? avl : vmax;
endfunction

function automatic logic [31:0] expected_vtype(input instr_word_u w);
    if (w.cfg.vsew == VSEW_INVALID) begin
        return 32'h8000_0000;
    end
    return {1'b0, 24'h0, w.cfg.agnostic, 1'b0, w.cfg.vsew, w.cfg.lmul};
endfunction

function automatic int unit_latency(input unit_e u);
    case (u)
        UNIT_ALU: return `LAT_ALU;
        UNIT_MUL: return `LAT_MUL;
        UNIT_SLD: return `LAT_SLD;
        default:  return `LAT_LSU;
    endcase
endfunction

function automatic logic [31:0] reg_mask(input logic [4:0] idx);
    return 32'h1 << idx;
endfunction

// a committed word gives exactly one result
task automatic record_commit(input instr_word_u w, input logic [31:0] avl);
    if (w.cfg.is_cfg) begin
        last_vl    = expected_vl(w, avl);
        last_vtype = expected_vtype(w);
        exp_xv.push_back(1'b1);
        exp_x.push_back(last_vl);
        exp_vtype.push_back(last_vtype);
    end else begin
        exp_xv.push_back(1'b0);
        exp_x.push_back(32'h0);
        exp_vtype.push_back(32'h0);
        exp_ops.push_back(w);
    end
endtask

// raw, war and waw against everything still busy at cyc
function automatic bit has_conflict(input logic [31:0] rd, input logic [31:0] wr, input int cyc);
    for (int i = 0; i < fl_due.size(); i++) begin
        if (fl_due[i] >= cyc &&
            ((rd & fl_wr[i]) | (wr & fl_rd[i]) | (wr & fl_wr[i])) != 32'h0) begin
            return 1'b1;
        end
    end
    return 1'b0;
endfunction

function automatic int count_inflight(input int cyc);
    int n;
    n = 0;
    foreach (fl_due[i]) begin
        if (fl_due[i] >= cyc) begin
            n++;
        end
    end
    return n;
endfunction

function automatic logic [31:0] due_mask(input int cyc);
    logic [31:0] m;
    m = 32'h0;
    foreach (fl_due[i]) begin
        if (fl_due[i] == cyc) begin
            m = m | fl_wr[i];
        end
    end
    return m;
endfunction

task automatic add_inflight(input logic [31:0] rd, input logic [31:0] wr, input int due);
    fl_rd.push_back(rd);
    fl_wr.push_back(wr);
    fl_due.push_back(due);
endtask

task automatic drop_retired(input int cyc);
    for (int i = fl_due.size() - 1; i >= 0; i--) begin
        if (fl_due[i] <= cyc) begin
            fl_due.delete(i);
            fl_rd.delete(i);
            fl_wr.delete(i);
        end
    end
endtask

`endif

// ==== bench/vfront_tb.sv ====
`default_nettype none

//////////////////////////////////////////////////
// testbench of the vector front end: random host traffic,
// result back-pressure and a cycle model of dispatch / retire
//////////////////////////////////////////////////

`include "vfront_defs.svh"

module vfront_tb;

    import vcfg_pkg::*;
    import vinstr_pkg::*;

    localparam int CLK_PERIOD = 4;
    localparam int NUM_INSTR  = 200;

    typedef enum {H_IDLE, H_REQ, H_WAIT} host_e;

    logic                  clk_i;
    logic                  async_rst_n;
    logic                  instr_valid_i;
    instr_word_u           instr_i;
    logic [31:0]           x_rs1_i;
    logic                  instr_gnt_o;
    logic                  instr_commit_i;
    logic                  instr_kill_i;
    logic                  result_ready_i;
    logic                  result_valid_o;
    logic                  xreg_valid_o;
    logic [31:0]           xreg_o;
    vtype_t                csr_vtype_o;
    logic [31:0]           csr_vl_o;
    logic                  dispatch_o;
    unit_e                 dispatch_unit_o;
    logic [4:0]            dispatch_vd_o;
    logic [`NUM_VREGS-1:0] retire_wr_mask_o;

    integer      seed;
    int          errors, checks, cycle, issued;
    host_e       host_state;
    instr_word_u cur_word;
    logic [31:0] cur_avl;
    bit          cur_kill;
    int          wait_left;
    bit          stall_q;                // result held back last cycle
    bit          held_xv;
    logic [31:0] held_x;

    `include "vfront_model.svh"

    vfront_top uut (
        .clk_i            (clk_i),
        .async_rst_n      (async_rst_n),
        .instr_valid_i    (instr_valid_i),
        .instr_i          (instr_i),
        .x_rs1_i          (x_rs1_i),
        .instr_gnt_o      (instr_gnt_o),
        .instr_commit_i   (instr_commit_i),
        .instr_kill_i     (instr_kill_i),
        .result_ready_i   (result_ready_i),
        .result_valid_o   (result_valid_o),
        .xreg_valid_o     (xreg_valid_o),
        .xreg_o           (xreg_o),
        .csr_vtype_o      (csr_vtype_o),
        .csr_vl_o         (csr_vl_o),
        .dispatch_o       (dispatch_o),
        .dispatch_unit_o  (dispatch_unit_o),
        .dispatch_vd_o    (dispatch_vd_o),
        .retire_wr_mask_o (retire_wr_mask_o)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %s exp %08h got %08h (cycle %0d)", name, exp, got, cycle);
        end
    endtask

    task automatic report_failure(input string msg);
        errors++;
        $display("cycle %0d: %s", cycle, msg);
    endtask

    ////////////////////////////////////////////////// host side

    task automatic make_instr();
        logic [31:0] r;
        r        = $random(seed);
        cur_word = '0;
        if (r[2:0] < 3'd3) begin                 // roughly 3 in 8 are configs
            cur_word.cfg.is_cfg   = 1'b1;
            cur_word.cfg.agnostic = r[4:3];
            cur_word.cfg.vsew     = vsew_e'(r[6:5]);
            cur_word.cfg.lmul     = lmul_e'(r[8:7]);
        end else begin
            cur_word.op.unit = unit_e'(r[4:3]);
            cur_word.op.vd   = {2'b00, r[7:5]};  // few registers, more hazards
            cur_word.op.vs1  = {2'b00, r[10:8]};
            cur_word.op.vs2  = {2'b00, r[13:11]};
        end
        cur_avl   = r[15] ? {26'h0, r[21:16]} : $random(seed);
        cur_kill  = (r[23:22] == 2'b00);
        wait_left = r[25:24];
    endtask

    task automatic drive_host();
        instr_commit_i = 1'b0;
        instr_kill_i   = 1'b0;
        if (host_state == H_IDLE) begin
            instr_valid_i = 1'b0;
            if (issued < NUM_INSTR && ($random(seed) & 3) != 0) begin
                make_instr();
                instr_i       = cur_word;
                x_rs1_i       = cur_avl;
                instr_valid_i = 1'b1;
                issued++;
                host_state = H_REQ;
            end
        end else if (host_state == H_WAIT) begin
            instr_valid_i = 1'b0;
            if (wait_left == 0) begin
                if (cur_kill) begin
                    instr_kill_i = 1'b1;
                end else begin
                    instr_commit_i = 1'b1;
                    record_commit(cur_word, cur_avl);
                end
                host_state = H_IDLE;
            end else begin
                wait_left--;
            end
        end
    endtask

    ////////////////////////////////////////////////// per-cycle checks

    task automatic check_cycle();
        bit          xv;
        logic [31:0] x, vt, rd, wr;
        instr_word_u w;
        if (stall_q) begin                       // result must hold while not taken
            check_value("result_valid_o", 32'h1, result_valid_o);
            check_value("xreg_valid_o", held_xv, xreg_valid_o);
            check_value("xreg_o", held_x, xreg_o);
        end
        if (result_valid_o && result_ready_i) begin
            if (exp_xv.size() == 0) begin
                report_failure("result returned with no committed instruction pending");
            end else begin
                xv = exp_xv.pop_front();
                x  = exp_x.pop_front();
                vt = exp_vtype.pop_front();
                check_value("xreg_valid_o", xv, xreg_valid_o);
                if (xv) begin
                    check_value("xreg_o", x, xreg_o);
                    check_value("csr_vl_o", x, csr_vl_o);
                    check_value("csr_vtype_o", vt, csr_vtype_o);
                end
            end
        end
        stall_q = result_valid_o && !result_ready_i;
        held_xv = xreg_valid_o;
        held_x  = xreg_o;

        check_value("retire_wr_mask_o", due_mask(cycle), retire_wr_mask_o);
        if (dispatch_o) begin
            if (exp_ops.size() == 0) begin
                report_failure("dispatch with no committed operation waiting");
            end else begin
                w  = exp_ops.pop_front();
                rd = reg_mask(w.op.vs1) | reg_mask(w.op.vs2);
                wr = reg_mask(w.op.vd);
                check_value("dispatch_unit_o", w.op.unit, dispatch_unit_o);
                check_value("dispatch_vd_o", w.op.vd, dispatch_vd_o);
                if (has_conflict(rd, wr, cycle)) begin
                    report_failure("operation dispatched over a register still in flight");
                end
                if (count_inflight(cycle) >= `EXEC_SLOTS) begin
                    report_failure("operation dispatched with every slot busy");
                end
                add_inflight(rd, wr, cycle + unit_latency(w.op.unit));
            end
        end
        drop_retired(cycle);
    endtask

    task automatic step_cycle();
        @(negedge clk_i);
        drive_host();
        result_ready_i = ($random(seed) & 3) != 0;   // low about a quarter of the time
        #1;
        check_cycle();
        if (host_state == H_REQ && instr_gnt_o) begin
            host_state = H_WAIT;
        end
        cycle++;
    endtask

    function automatic bit all_done();
        return issued == NUM_INSTR && host_state == H_IDLE && exp_xv.size() == 0 &&
               exp_ops.size() == 0 && fl_due.size() == 0;
    endfunction

    initial begin
        seed           = 33477;
        clk_i          = 1'b0;
        async_rst_n    = 1'b0;
        instr_valid_i  = 1'b0;
        instr_i        = '0;
        x_rs1_i        = 32'h0;
        instr_commit_i = 1'b0;
        instr_kill_i   = 1'b0;
        result_ready_i = 1'b0;
        errors         = 0;
        checks         = 0;
        cycle          = 0;
        issued         = 0;
        host_state     = H_IDLE;
        stall_q        = 1'b0;

        repeat (5) @(negedge clk_i);
        async_rst_n = 1'b1;
        #1;
        check_value("instr_gnt_o", 32'h0, instr_gnt_o);
        check_value("result_valid_o", 32'h0, result_valid_o);
        check_value("xreg_valid_o", 32'h0, xreg_valid_o);
        check_value("dispatch_o", 32'h0, dispatch_o);
        check_value("retire_wr_mask_o", 32'h0, retire_wr_mask_o);
        check_value("csr_vtype_o", 32'h8000_0000, csr_vtype_o);
        check_value("csr_vl_o", 32'h0, csr_vl_o);

        while (!all_done()) begin
            step_cycle();
        end

        // last result taken above leaves the register on the next edge
        @(negedge clk_i);
        #1;

        // configuration left by the last committed vsetvl
        check_value("csr_vl_o", last_vl, csr_vl_o);
        check_value("csr_vtype_o", last_vtype, csr_vtype_o);
        check_value("result_valid_o", 32'h0, result_valid_o);

        $display("%0d instructions, %0d checks, %0d errors", issued, checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // watchdog, generous bound per instruction
    initial begin
        #(NUM_INSTR * 40 * CLK_PERIOD);
        $display("timeout: run did not finish within %0d cycles, %0d errors so far",
                 NUM_INSTR * 40, errors);
        $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+hw
+incdir+bench
hw/vcfg_pkg.sv
hw/vinstr_pkg.sv
hw/commit_ctrl.sv
hw/vcfg_state.sv
hw/issue_queue.sv
hw/hazard_check.sv
hw/exec_timer.sv
hw/vfront_top.sv
bench/vfront_tb.sv

// ==== hw/commit_ctrl.sv ====
`default_nettype none

//////////////////////////////////////////////////
// single-entry decode buffer with host commit / kill,
// plus the result register handed back to the host
//////////////////////////////////////////////////

module commit_ctrl (
    input  wire logic                    clk_i,
    input  wire logic                    async_rst_n,
    input  wire logic                    instr_valid_i,
    input  wire vinstr_pkg::instr_word_u instr_i,
    input  wire logic [31:0]             x_rs1_i,        // AVL, sampled with the grant
    input  wire logic                    instr_commit_i,
    input  wire logic                    instr_kill_i,
    input  wire logic                    result_ready_i,
    input  wire logic                    queue_full_i,
    input  wire logic [31:0]             new_vl_i,
    output logic                         instr_gnt_o,
    output logic                         cfg_load_o,
    output vinstr_pkg::instr_word_u      held_word_o,
    output logic [31:0]                  held_avl_o,
    output logic                         push_o,
    output logic                         result_valid_o,
    output logic                         xreg_valid_o,
    output logic [31:0]                  xreg_o
);

    import vinstr_pkg::*;

    typedef enum logic [1:0] {EMPTY, HELD, COMMITTED} state_e;

    state_e      state_q, state_d;
    instr_word_u word_q;             // decode buffer
    logic [31:0] avl_q;
    logic        is_cfg;
    logic        res_free, allowed, commit_now, complete;
    logic        result_valid_q, xreg_valid_q;
    logic [31:0] xreg_q;

    assign instr_gnt_o = instr_valid_i & (state_q == EMPTY);
    assign is_cfg      = word_q.cfg.is_cfg;   // top bit picks the view

    // result slot is usable when empty or drained this cycle
    assign res_free   = ~result_valid_q | result_ready_i;
    assign allowed    = res_free & (is_cfg | ~queue_full_i);
    assign commit_now = ((state_q == HELD) & instr_commit_i) | (state_q == COMMITTED);
    assign complete   = commit_now & allowed;

    assign cfg_load_o  = complete & is_cfg;
    assign push_o      = complete & ~is_cfg;
    assign held_word_o = word_q;
    assign held_avl_o  = avl_q;

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            EMPTY: begin
                if (instr_gnt_o) begin
                    state_d = HELD;
                end
            end
            HELD: begin
                if (instr_kill_i) begin
                    state_d = EMPTY;                 // dropped, no result
                end else if (instr_commit_i) begin
                    state_d = complete ? EMPTY : COMMITTED;
                end
            end
            COMMITTED: begin
                if (complete) begin
                    state_d = EMPTY;
                end
            end
            default: state_d = EMPTY;
        endcase
    end

    always_ff @(posedge clk_i or negedge async_rst_n) begin
        if (!async_rst_n) begin
            state_q        <= EMPTY;
            result_valid_q <= 1'b0;
            xreg_valid_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            if (complete) begin
                result_valid_q <= 1'b1;
                xreg_valid_q   <= is_cfg;    // only vsetvl returns a value
            end else if (result_ready_i) begin
                result_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (instr_gnt_o) begin
            word_q <= instr_i;
            avl_q  <= x_rs1_i;
        end
        if (complete) begin
            xreg_q <= is_cfg ? new_vl_i : 32'h0;
        end
    end

    assign result_valid_o = result_valid_q;
    assign xreg_valid_o   = result_valid_q & xreg_valid_q;
    assign xreg_o         = xreg_q;

    // host answers each granted instruction with one of the two
    assert property (@(posedge clk_i) disable iff (!async_rst_n)
        (state_q == HELD) |-> !(instr_commit_i && instr_kill_i));

endmodule

`default_nettype wire

// ==== hw/exec_timer.sv ====
`default_nettype none

//////////////////////////////////////////////////
// stand-in for the execution units: each slot holds an
// operation for its unit latency, then retires it
//////////////////////////////////////////////////

`include "vfront_defs.svh"

module exec_timer (
    input  wire logic                  clk_i,
    input  wire logic                  async_rst_n,
    input  wire logic                  dispatch_i,
    input  wire vinstr_pkg::unit_e     unit_i,
    input  wire logic [`NUM_VREGS-1:0] rd_mask_i,
    input  wire logic [`NUM_VREGS-1:0] wr_mask_i,
    output logic                       slot_free_o,
    output logic [`NUM_VREGS-1:0]      busy_rd_map_o,
    output logic [`NUM_VREGS-1:0]      busy_wr_map_o,
    output logic [`NUM_VREGS-1:0]      retire_wr_mask_o
);

    import vinstr_pkg::*;

    localparam int CNT_W = $clog2(`LAT_LSU + 1);

    logic [`EXEC_SLOTS-1:0] valid_q, alloc, done;
    logic [CNT_W-1:0]       cnt_q [`EXEC_SLOTS];
    logic [`NUM_VREGS-1:0]  rd_q  [`EXEC_SLOTS];
    logic [`NUM_VREGS-1:0]  wr_q  [`EXEC_SLOTS];
    logic [CNT_W-1:0]       lat;

    always_comb begin
        unique case (unit_i)
            UNIT_ALU: lat = CNT_W'(`LAT_ALU);
            UNIT_MUL: lat = CNT_W'(`LAT_MUL);
            UNIT_SLD: lat = CNT_W'(`LAT_SLD);
            default:  lat = CNT_W'(`LAT_LSU);
        endcase
    end

    // lowest free slot takes the dispatch
    always_comb begin
        alloc = '0;
        for (int i = 0; i < `EXEC_SLOTS; i++) begin
            if (!valid_q[i] && alloc == '0) begin
                alloc[i] = dispatch_i;
            end
        end
    end

    ////////////////////////////////////////////////// busy and retire maps

    always_comb begin
        busy_rd_map_o    = '0;
        busy_wr_map_o    = '0;
        retire_wr_mask_o = '0;
        for (int i = 0; i < `EXEC_SLOTS; i++) begin
            done[i] = valid_q[i] && (cnt_q[i] == CNT_W'(1));   // last busy cycle
            if (valid_q[i]) begin
                busy_rd_map_o = busy_rd_map_o | rd_q[i];
                busy_wr_map_o = busy_wr_map_o | wr_q[i];
            end
            if (done[i]) begin
                retire_wr_mask_o = retire_wr_mask_o | wr_q[i];
            end
        end
    end

    assign slot_free_o = ~&valid_q;

    always_ff @(posedge clk_i or negedge async_rst_n) begin
        if (!async_rst_n) begin
            valid_q <= '0;
        end else begin
            valid_q <= (valid_q & ~done) | alloc;
        end
    end

    always_ff @(posedge clk_i) begin
        for (int i = 0; i < `EXEC_SLOTS; i++) begin
            if (alloc[i]) begin
                cnt_q[i] <= lat;
                rd_q[i]  <= rd_mask_i;
                wr_q[i]  <= wr_mask_i;
            end else if (valid_q[i]) begin
                cnt_q[i] <= cnt_q[i] - 1'b1;
            end
        end
    end

    // the hazard check must not issue into a full timer
    assert property (@(posedge clk_i) disable iff (!async_rst_n)
        dispatch_i |-> slot_free_o);

endmodule

`default_nettype wire

// ==== hw/hazard_check.sv ====
`default_nettype none

//////////////////////////////////////////////////
// register masks of the queue head and the dispatch
// decision against the in-flight busy maps
//////////////////////////////////////////////////

`include "vfront_defs.svh"

module hazard_check (
    input  wire logic                    head_valid_i,
    input  wire vinstr_pkg::instr_word_u head_word_i,
    input  wire logic [`NUM_VREGS-1:0]   busy_rd_map_i,
    input  wire logic [`NUM_VREGS-1:0]   busy_wr_map_i,
    input  wire logic                    slot_free_i,
    output logic                         dispatch_o,
    output vinstr_pkg::unit_e            unit_o,
    output logic [4:0]                   vd_o,
    output logic [`NUM_VREGS-1:0]        rd_mask_o,
    output logic [`NUM_VREGS-1:0]        wr_mask_o
);

    import vinstr_pkg::*;

    op_view_t op;
    logic     raw, war, waw;

    function automatic logic [`NUM_VREGS-1:0] reg_bit(input logic [4:0] idx);
        logic [`NUM_VREGS-1:0] mask;
        mask      = '0;
        mask[idx] = 1'b1;
        return mask;
    endfunction

    assign op        = head_word_i.op;       // queue only holds operations
    assign unit_o    = op.unit;
    assign vd_o      = op.vd;
    assign rd_mask_o = reg_bit(op.vs1) | reg_bit(op.vs2);
    assign wr_mask_o = reg_bit(op.vd);

    assign raw = |(rd_mask_o & busy_wr_map_i);
    assign war = |(wr_mask_o & busy_rd_map_i);
    assign waw = |(wr_mask_o & busy_wr_map_i);

    assign dispatch_o = head_valid_i & slot_free_i & ~(raw | war | waw);

endmodule

`default_nettype wire

// ==== hw/issue_queue.sv ====
`default_nettype none

//////////////////////////////////////////////////
// in-order FIFO of committed vector operations
//////////////////////////////////////////////////

`include "vfront_defs.svh"

module issue_queue (
    input  wire logic                    clk_i,
    input  wire logic                    async_rst_n,
    input  wire logic                    push_i,
    input  wire vinstr_pkg::instr_word_u push_word_i,
    input  wire logic                    pop_i,
    output logic                         full_o,
    output logic                         head_valid_o,
    output vinstr_pkg::instr_word_u      head_word_o
);

    import vinstr_pkg::*;

    localparam int PTR_W = $clog2(`QUEUE_DEPTH);

    instr_word_u    mem_q [`QUEUE_DEPTH];
    logic [PTR_W:0] wr_ptr_q, rd_ptr_q;       // extra bit tells full from empty

    assign head_valid_o = (wr_ptr_q != rd_ptr_q);
    assign full_o       = (wr_ptr_q[PTR_W] != rd_ptr_q[PTR_W]) &&
                          (wr_ptr_q[PTR_W-1:0] == rd_ptr_q[PTR_W-1:0]);
    assign head_word_o  = mem_q[rd_ptr_q[PTR_W-1:0]];

    always_ff @(posedge clk_i or negedge async_rst_n) begin
        if (!async_rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop_i) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem_q[wr_ptr_q[PTR_W-1:0]] <= push_word_i;
        end
    end

    // dispatch only ever takes a valid head
    assert property (@(posedge clk_i) disable iff (!async_rst_n)
        pop_i |-> head_valid_o);

    // commit stage never pushes into a full queue
    assert property (@(posedge clk_i) disable iff (!async_rst_n)
        push_i |-> !full_o);

endmodule

`default_nettype wire

// ==== hw/vcfg_pkg.sv ====
`default_nettype none

//////////////////////////////////////////////////
// vector configuration types: element width, register
// grouping and the vtype CSR layout
//////////////////////////////////////////////////

package vcfg_pkg;

    typedef enum logic [1:0] {
        VSEW_8       = 2'd0,
        VSEW_16      = 2'd1,
        VSEW_32      = 2'd2,
        VSEW_INVALID = 2'd3
    } vsew_e;

    typedef enum logic [1:0] {
        LMUL_1 = 2'd0,
        LMUL_2 = 2'd1,
        LMUL_4 = 2'd2,
        LMUL_8 = 2'd3     // code is log2 of the group size
    } lmul_e;

    typedef struct packed {
        logic        ill;        // bit 31, config not usable
        logic [23:0] zero_fill;
        logic [1:0]  agnostic;   // tail / mask policy
        logic        zero;
        vsew_e       vsew;
        lmul_e       lmul;
    } vtype_t;

endpackage

`default_nettype wire

// ==== hw/vcfg_state.sv ====
`default_nettype none

//////////////////////////////////////////////////
// vtype / vl registers; computes the new vl of a
// configuration word and drives the CSR read values
//////////////////////////////////////////////////

`include "vfront_defs.svh"

module vcfg_state (
    input  wire logic                    clk_i,
    input  wire logic                    async_rst_n,
    input  wire logic                    cfg_load_i,
    input  wire vinstr_pkg::instr_word_u cfg_word_i,
    input  wire logic [31:0]             avl_i,
    output logic [31:0]                  new_vl_o,
    output vcfg_pkg::vtype_t             csr_vtype_o,
    output logic [31:0]                  csr_vl_o
);

    import vcfg_pkg::*;
    import vinstr_pkg::*;

    vsew_e       vsew_q;
    lmul_e       lmul_q;
    logic [1:0]  agnostic_q;
    logic [31:0] vl_q;
    cfg_view_t   cfg;
    logic [31:0] vlmax;

    assign cfg = cfg_word_i.cfg;

    // elements per register at the new width, times the group size
    assign vlmax = (32'(`VREG_W / 8) >> cfg.vsew) << cfg.lmul;

    always_comb begin
        if (cfg.vsew == VSEW_INVALID || avl_i == 32'h0) begin
            new_vl_o = 32'h0;
        end else if (avl_i < vlmax) begin
            new_vl_o = avl_i;
        end else begin
            new_vl_o = vlmax;              // clamp to VLMAX
        end
    end

    always_ff @(posedge clk_i or negedge async_rst_n) begin
        if (!async_rst_n) begin
            vsew_q     <= VSEW_INVALID;
            lmul_q     <= LMUL_1;
            agnostic_q <= 2'b00;
            vl_q       <= 32'h0;
        end else if (cfg_load_i) begin
            vsew_q     <= cfg.vsew;
            lmul_q     <= cfg.lmul;
            agnostic_q <= cfg.agnostic;
            vl_q       <= new_vl_o;
        end
    end

    ////////////////////////////////////////////////// CSR reads

    always_comb begin
        csr_vtype_o = '0;
        if (vsew_q == VSEW_INVALID) begin
            csr_vtype_o.ill = 1'b1;        // rest reads as zero
        end else begin
            csr_vtype_o.agnostic = agnostic_q;
            csr_vtype_o.vsew     = vsew_q;
            csr_vtype_o.lmul     = lmul_q;
        end
    end

    assign csr_vl_o = vl_q;

endmodule

`default_nettype wire

// ==== hw/vfront_defs.svh ====
//////////////////////////////////////////////////
// sizes and unit latencies of the vector front end,
// included by every block that needs a width or depth
//////////////////////////////////////////////////

`ifndef VFRONT_DEFS_SVH
`define VFRONT_DEFS_SVH

`define VREG_W      128     // vector register width in bits
`define NUM_VREGS   32      // also the width of every hazard mask

`define QUEUE_DEPTH 4       // power of two
`define EXEC_SLOTS  4       // operations in flight at once

// cycles from dispatch to retire, per unit class
`define LAT_ALU     2
`define LAT_MUL     4
`define LAT_SLD     3
`define LAT_LSU     6       // longest one, sizes the slot counters

`endif

// ==== hw/vfront_top.sv ====
`default_nettype none

//////////////////////////////////////////////////
// vector coprocessor front end: commit stage, config,
// issue queue, hazard check and execution timer
//////////////////////////////////////////////////

`include "vfront_defs.svh"

module vfront_top (
    input  wire logic                    clk_i,
    input  wire logic                    async_rst_n,
    input  wire logic                    instr_valid_i,
    input  wire vinstr_pkg::instr_word_u instr_i,
    input  wire logic [31:0]             x_rs1_i,
    output logic                         instr_gnt_o,
    input  wire logic                    instr_commit_i,
    input  wire logic                    instr_kill_i,
    input  wire logic                    result_ready_i,
    output logic                         result_valid_o,
    output logic                         xreg_valid_o,
    output logic [31:0]                  xreg_o,
    output vcfg_pkg::vtype_t             csr_vtype_o,
    output logic [31:0]                  csr_vl_o,
    output logic                         dispatch_o,
    output vinstr_pkg::unit_e            dispatch_unit_o,
    output logic [4:0]                   dispatch_vd_o,
    output logic [`NUM_VREGS-1:0]        retire_wr_mask_o
);

    import vinstr_pkg::*;

    logic                  push, queue_full, cfg_load;
    instr_word_u           held_word;
    logic [31:0]           held_avl, new_vl;
    logic                  head_valid;       // queue head into hazard check
    instr_word_u           head_word;
    logic                  slot_free;
    logic [`NUM_VREGS-1:0] busy_rd_map, busy_wr_map, rd_mask, wr_mask;

    commit_ctrl u_commit (
        .clk_i          (clk_i),
        .async_rst_n    (async_rst_n),
        .instr_valid_i  (instr_valid_i),
        .instr_i        (instr_i),
        .x_rs1_i        (x_rs1_i),
        .instr_commit_i (instr_commit_i),
        .instr_kill_i   (instr_kill_i),
        .result_ready_i (result_ready_i),
        .queue_full_i   (queue_full),
        .new_vl_i       (new_vl),
        .instr_gnt_o    (instr_gnt_o),
        .cfg_load_o     (cfg_load),
        .held_word_o    (held_word),
        .held_avl_o     (held_avl),
        .push_o         (push),
        .result_valid_o (result_valid_o),
        .xreg_valid_o   (xreg_valid_o),
        .xreg_o         (xreg_o)
    );

    vcfg_state u_cfg (
        .clk_i       (clk_i),
        .async_rst_n (async_rst_n),
        .cfg_load_i  (cfg_load),
        .cfg_word_i  (held_word),
        .avl_i       (held_avl),
        .new_vl_o    (new_vl),
        .csr_vtype_o (csr_vtype_o),
        .csr_vl_o    (csr_vl_o)
    );

    issue_queue u_queue (
        .clk_i        (clk_i),
        .async_rst_n  (async_rst_n),
        .push_i       (push),
        .push_word_i  (held_word),
        .pop_i        (dispatch_o),
        .full_o       (queue_full),
        .head_valid_o (head_valid),
        .head_word_o  (head_word)
    );

    hazard_check u_hazard (
        .head_valid_i  (head_valid),
        .head_word_i   (head_word),
        .busy_rd_map_i (busy_rd_map),
        .busy_wr_map_i (busy_wr_map),
        .slot_free_i   (slot_free),
        .dispatch_o    (dispatch_o),
        .unit_o        (dispatch_unit_o),
        .vd_o          (dispatch_vd_o),
        .rd_mask_o     (rd_mask),
        .wr_mask_o     (wr_mask)
    );

    exec_timer u_timer (
        .clk_i            (clk_i),
        .async_rst_n      (async_rst_n),
        .dispatch_i       (dispatch_o),
        .unit_i           (dispatch_unit_o),
        .rd_mask_i        (rd_mask),
        .wr_mask_i        (wr_mask),
        .slot_free_o      (slot_free),
        .busy_rd_map_o    (busy_rd_map),
        .busy_wr_map_o    (busy_wr_map),
        .retire_wr_mask_o (retire_wr_mask_o)
    );

endmodule

`default_nettype wire

// ==== hw/vinstr_pkg.sv ====
`default_nettype none

//////////////////////////////////////////////////
// pre-decoded instruction word and its two views;
// bit 31 selects between configuration and operation
//////////////////////////////////////////////////

package vinstr_pkg;

    typedef enum logic [1:0] {
        UNIT_ALU = 2'd0,
        UNIT_MUL = 2'd1,
        UNIT_SLD = 2'd2,
        UNIT_LSU = 2'd3
    } unit_e;

    // vsetvl style word, AVL travels separately in x_rs1
    typedef struct packed {
        logic            is_cfg;      // set for this view
        logic [24:0]     zero_fill;
        logic [1:0]      agnostic;
        vcfg_pkg::vsew_e vsew;
        vcfg_pkg::lmul_e lmul;
    } cfg_view_t;

    typedef struct packed {
        logic        is_cfg;          // clear for this view
        logic [13:0] zero_fill;
        unit_e       unit;
        logic [4:0]  vd;
        logic [4:0]  vs1;
        logic [4:0]  vs2;
    } op_view_t;

    typedef union packed {
        cfg_view_t cfg;
        op_view_t  op;
    } instr_word_u;

endpackage

`default_nettype wire
